// File: sim.f
source/mmu_pkg.sv
source/trans_fsm.sv
source/tlb_walk_timer.sv
source/tlb_array.sv
source/seg_cache.sv
source/m1_stage.sv
source/daddr_trans_top.sv
testbench/tb_daddr_trans.sv

// File: source/daddr_trans_top.sv
module daddr_trans_top
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES   = 8,
    parameter int LOOKUP_CYCLES = 3
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           valid_i,
    input  logic [31:0]                    vaddr_i,
    input  logic                           m1_stall_i,
    input  logic                           flush_i,
    input  logic                           crmd_da_i,
    input  logic [PLV_W-1:0]               crmd_plv_i,
    input  logic [MAT_W-1:0]               crmd_datm_i,
    input  logic [SEG_W-1:0]               dmw0_vseg_i,
    input  logic [SEG_W-1:0]               dmw0_pseg_i,
    input  logic [MAT_W-1:0]               dmw0_mat_i,
    input  logic [PLV_W-1:0]               dmw0_plv_i,
    input  logic [SEG_W-1:0]               dmw1_vseg_i,
    input  logic [SEG_W-1:0]               dmw1_pseg_i,
    input  logic [MAT_W-1:0]               dmw1_mat_i,
    input  logic [PLV_W-1:0]               dmw1_plv_i,
    input  logic                           tlb_we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_wr_index_i,
    input  logic [31-PAGE_SHIFT:0]         tlb_wr_vpn_i,
    input  logic [PPN_W-1:0]               tlb_wr_ppn_i,
    input  logic [MAT_W-1:0]               tlb_wr_mat_i,
    input  logic [PLV_W-1:0]               tlb_wr_plv_i,
    input  logic                           tlb_wr_valid_i,
    output logic                           ready_o,
    output logic [PPN_W-1:0]               ppn_o,
    output logic [MAT_W-1:0]               mat_o,
    output logic [PLV_W-1:0]               plv_o,
    output logic                           found_o,
    output logic                           dmw_o
);

    logic             cache_valid;
    logic             cache_istlb;
    logic             cache_found;
    logic [PPN_W-1:0] cache_ppn;
    logic [MAT_W-1:0] cache_mat;
    logic [PLV_W-1:0] cache_plv;
    logic [TAG_W-1:0] cache_tag;
    logic             m1_miss;
    logic [31:0]      m1_vaddr;
    trans_state_e     state;
    logic             walk_start;
    logic             walk_done;
    logic             tlb_found;
    logic [PPN_W-1:0] tlb_ppn;
    logic [MAT_W-1:0] tlb_mat;
    logic [PLV_W-1:0] tlb_plv;

    // same condition that takes the FSM from NORMAL into REFILL
    assign walk_start = (state == NORMAL) && m1_miss && !flush_i;

    trans_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .flush_i(flush_i),
        .m1_miss_i(m1_miss), .walk_done_i(walk_done), .state_o(state)
    );

    tlb_walk_timer #(.LOOKUP_CYCLES(LOOKUP_CYCLES)) u_timer (
        .clk(clk), .rst_n(rst_n), .start_i(walk_start), .done_o(walk_done)
    );

    tlb_array #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb (
        .clk(clk), .rst_n(rst_n), .we_i(tlb_we_i), .wr_index_i(tlb_wr_index_i),
        .wr_vpn_i(tlb_wr_vpn_i), .wr_ppn_i(tlb_wr_ppn_i), .wr_mat_i(tlb_wr_mat_i),
        .wr_plv_i(tlb_wr_plv_i), .wr_valid_i(tlb_wr_valid_i), .lookup_vaddr_i(m1_vaddr),
        .found_o(tlb_found), .ppn_o(tlb_ppn), .mat_o(tlb_mat), .plv_o(tlb_plv)
    );

    seg_cache u_cache (
        .clk(clk), .rst_n(rst_n), .flush_i(flush_i), .state_i(state),
        .crmd_da_i(crmd_da_i), .crmd_plv_i(crmd_plv_i), .crmd_datm_i(crmd_datm_i),
        .dmw0_vseg_i(dmw0_vseg_i), .dmw0_pseg_i(dmw0_pseg_i),
        .dmw0_mat_i(dmw0_mat_i), .dmw0_plv_i(dmw0_plv_i),
        .dmw1_vseg_i(dmw1_vseg_i), .dmw1_pseg_i(dmw1_pseg_i),
        .dmw1_mat_i(dmw1_mat_i), .dmw1_plv_i(dmw1_plv_i),
        .refill_i(walk_done), .refill_seg_i(m1_vaddr[31 -: SEG_W]),
        .refill_tag_i(m1_vaddr[PAGE_SHIFT +: TAG_W]), .refill_found_i(tlb_found),
        .refill_ppn_i(tlb_ppn), .refill_mat_i(tlb_mat), .refill_plv_i(tlb_plv),
        .rd_seg_i(vaddr_i[31 -: SEG_W]),
        .cache_valid_o(cache_valid), .cache_istlb_o(cache_istlb),
        .cache_found_o(cache_found), .cache_ppn_o(cache_ppn),
        .cache_mat_o(cache_mat), .cache_plv_o(cache_plv), .cache_tag_o(cache_tag)
    );

    m1_stage u_m1 (
        .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .vaddr_i(vaddr_i),
        .m1_stall_i(m1_stall_i), .crmd_da_i(crmd_da_i),
        .crmd_plv_i(crmd_plv_i), .crmd_datm_i(crmd_datm_i),
        .cache_valid_i(cache_valid), .cache_istlb_i(cache_istlb),
        .cache_found_i(cache_found), .cache_ppn_i(cache_ppn),
        .cache_mat_i(cache_mat), .cache_plv_i(cache_plv), .cache_tag_i(cache_tag),
        .walk_done_i(walk_done), .tlb_found_i(tlb_found), .tlb_ppn_i(tlb_ppn),
        .tlb_mat_i(tlb_mat), .tlb_plv_i(tlb_plv),
        .m1_vaddr_o(m1_vaddr), .m1_miss_o(m1_miss), .ready_o(ready_o),
        .ppn_o(ppn_o), .mat_o(mat_o), .plv_o(plv_o), .found_o(found_o), .dmw_o(dmw_o)
    );

endmodule

// File: source/m1_stage.sv
module m1_stage
    import mmu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_i,
    input  logic [31:0]      vaddr_i,
    input  logic             m1_stall_i,
    input  logic             crmd_da_i,
    input  logic [PLV_W-1:0] crmd_plv_i,
    input  logic [MAT_W-1:0] crmd_datm_i,
    input  logic             cache_valid_i,
    input  logic             cache_istlb_i,
    input  logic             cache_found_i,
    input  logic [PPN_W-1:0] cache_ppn_i,
    input  logic [MAT_W-1:0] cache_mat_i,
    input  logic [PLV_W-1:0] cache_plv_i,
    input  logic [TAG_W-1:0] cache_tag_i,
    input  logic             walk_done_i,
    input  logic             tlb_found_i,
    input  logic [PPN_W-1:0] tlb_ppn_i,
    input  logic [MAT_W-1:0] tlb_mat_i,
    input  logic [PLV_W-1:0] tlb_plv_i,
    output logic [31:0]      m1_vaddr_o,
    output logic             m1_miss_o,
    output logic             ready_o,
    output logic [PPN_W-1:0] ppn_o,
    output logic [MAT_W-1:0] mat_o,
    output logic [PLV_W-1:0] plv_o,
    output logic             found_o,
    output logic             dmw_o
);

    logic             valid_q;
    logic             istlb_q;
    logic             tag_miss_q;
    logic             da_q;
    logic             found_q;
    logic [PPN_W-1:0] ppn_q;
    logic [MAT_W-1:0] mat_q;
    logic [PLV_W-1:0] plv_q;
    logic [31:0]      vaddr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // nothing in flight so report ready
            valid_q    <= 1'b1;
            istlb_q    <= 1'b0;
            tag_miss_q <= 1'b0;
            da_q       <= 1'b0;
        end else if (walk_done_i) begin
            valid_q    <= 1'b1;
            istlb_q    <= 1'b1;
            tag_miss_q <= 1'b0;
        end else if (!m1_stall_i) begin
            // idle slots and DA mode never miss
            valid_q    <= cache_valid_i || !valid_i || crmd_da_i;
            istlb_q    <= cache_istlb_i && valid_i && !crmd_da_i;
            tag_miss_q <= cache_tag_i != vaddr_i[PAGE_SHIFT +: TAG_W];
            da_q       <= crmd_da_i;
        end
    end

    always_ff @(posedge clk) begin
        if (walk_done_i) begin
            found_q <= tlb_found_i;
            ppn_q   <= tlb_ppn_i;
            mat_q   <= tlb_mat_i;
            plv_q   <= tlb_plv_i;
        end else if (!m1_stall_i) begin
            found_q <= cache_found_i;
            ppn_q   <= cache_ppn_i;
            mat_q   <= crmd_da_i ? crmd_datm_i : cache_mat_i;
            plv_q   <= crmd_da_i ? crmd_plv_i : cache_plv_i;
            vaddr_q <= vaddr_i;
        end
    end

    always_comb begin
        m1_miss_o = !valid_q || (istlb_q && tag_miss_q);
        ready_o   = !m1_miss_o;
        mat_o     = mat_q;
        plv_o     = plv_q;
        dmw_o     = !istlb_q;
        if (da_q) begin
            ppn_o   = vaddr_q[31:PAGE_SHIFT];
            found_o = 1'b1;
        end else if (istlb_q) begin
            ppn_o   = ppn_q;
            found_o = found_q;
        end else begin
            // window hit puts pseg on top of the page within the segment
            ppn_o   = {ppn_q[PPN_W-1 -: SEG_W], vaddr_q[PAGE_SHIFT +: TAG_W]};
            found_o = found_q;
        end
    end

    assign m1_vaddr_o = vaddr_q;

endmodule

// File: source/mmu_pkg.sv
package mmu_pkg;

    // translation table sequencing
    typedef enum logic [1:0] {
        NORMAL    = 2'd0,
        LOAD_DMW0 = 2'd1,
        LOAD_DMW1 = 2'd2,
        REFILL    = 2'd3
    } trans_state_e;

    localparam int PPN_W      = 20;
    // page index vaddr[28:12] inside one 512 MB segment
    localparam int TAG_W      = 17;
    localparam int SEG_W      = 3;
    localparam int MAT_W      = 2;
    localparam int PLV_W      = 2;
    // fixed 4 KB pages
    localparam int PAGE_SHIFT = 12;

endpackage

// File: source/seg_cache.sv
module seg_cache
    import mmu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush_i,
    input  trans_state_e     state_i,
    input  logic             crmd_da_i,
    input  logic [PLV_W-1:0] crmd_plv_i,
    input  logic [MAT_W-1:0] crmd_datm_i,
    input  logic [SEG_W-1:0] dmw0_vseg_i,
    input  logic [SEG_W-1:0] dmw0_pseg_i,
    input  logic [MAT_W-1:0] dmw0_mat_i,
    input  logic [PLV_W-1:0] dmw0_plv_i,
    input  logic [SEG_W-1:0] dmw1_vseg_i,
    input  logic [SEG_W-1:0] dmw1_pseg_i,
    input  logic [MAT_W-1:0] dmw1_mat_i,
    input  logic [PLV_W-1:0] dmw1_plv_i,
    input  logic             refill_i,
    input  logic [SEG_W-1:0] refill_seg_i,
    input  logic [TAG_W-1:0] refill_tag_i,
    input  logic             refill_found_i,
    input  logic [PPN_W-1:0] refill_ppn_i,
    input  logic [MAT_W-1:0] refill_mat_i,
    input  logic [PLV_W-1:0] refill_plv_i,
    input  logic [SEG_W-1:0] rd_seg_i,
    output logic             cache_valid_o,
    output logic             cache_istlb_o,
    output logic             cache_found_o,
    output logic [PPN_W-1:0] cache_ppn_o,
    output logic [MAT_W-1:0] cache_mat_o,
    output logic [PLV_W-1:0] cache_plv_o,
    output logic [TAG_W-1:0] cache_tag_o
);

    localparam int SEGS = 2 ** SEG_W;

    logic [SEGS-1:0]  valid_q;
    logic [SEGS-1:0]  istlb_q;
    logic [SEGS-1:0]  found_q;
    logic [PPN_W-1:0] ppn_q [SEGS];
    logic [TAG_W-1:0] tag_q [SEGS];
    logic [MAT_W-1:0] mat_q [SEGS];
    logic [PLV_W-1:0] plv_q [SEGS];

    logic             wr_en;
    logic [SEG_W-1:0] wr_seg;
    logic             wr_istlb;
    logic             wr_found;
    logic [PPN_W-1:0] wr_ppn;
    logic [TAG_W-1:0] wr_tag;
    logic [MAT_W-1:0] wr_mat;
    logic [PLV_W-1:0] wr_plv;

    // window entries keep only pseg in the top of ppn
    always_comb begin
        wr_en    = 1'b0;
        wr_seg   = dmw0_vseg_i;
        wr_istlb = 1'b0;
        wr_found = 1'b1;
        wr_ppn   = {dmw0_pseg_i, {TAG_W{1'b0}}};
        wr_tag   = '0;
        wr_mat   = crmd_da_i ? crmd_datm_i : dmw0_mat_i;
        wr_plv   = crmd_da_i ? crmd_plv_i : dmw0_plv_i;
        case (state_i)
            LOAD_DMW0: wr_en = 1'b1;
            LOAD_DMW1: begin
                wr_en  = 1'b1;
                wr_seg = dmw1_vseg_i;
                wr_ppn = {dmw1_pseg_i, {TAG_W{1'b0}}};
                wr_mat = crmd_da_i ? crmd_datm_i : dmw1_mat_i;
                wr_plv = crmd_da_i ? crmd_plv_i : dmw1_plv_i;
            end
            default: begin
                if (refill_i) begin
                    wr_en    = 1'b1;
                    wr_seg   = refill_seg_i;
                    wr_istlb = 1'b1;
                    wr_found = refill_found_i;
                    wr_ppn   = refill_ppn_i;
                    wr_tag   = refill_tag_i;
                    wr_mat   = refill_mat_i;
                    wr_plv   = refill_plv_i;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            valid_q <= '0;
            istlb_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_seg] <= 1'b1;
            istlb_q[wr_seg] <= wr_istlb;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            found_q[wr_seg] <= wr_found;
            ppn_q[wr_seg]   <= wr_ppn;
            tag_q[wr_seg]   <= wr_tag;
            mat_q[wr_seg]   <= wr_mat;
            plv_q[wr_seg]   <= wr_plv;
        end
    end

    assign cache_valid_o = valid_q[rd_seg_i];
    assign cache_istlb_o = istlb_q[rd_seg_i];
    assign cache_found_o = found_q[rd_seg_i];
    assign cache_ppn_o   = ppn_q[rd_seg_i];
    assign cache_tag_o   = tag_q[rd_seg_i];
    assign cache_mat_o   = mat_q[rd_seg_i];
    assign cache_plv_o   = plv_q[rd_seg_i];

    // a refill landing during preload would be lost to the window write
    no_refill_in_preload: assert property (
        @(posedge clk) disable iff (!rst_n)
        refill_i |-> !(state_i inside {LOAD_DMW0, LOAD_DMW1})
    );

endmodule

// File: source/tlb_array.sv
module tlb_array
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0] wr_index_i,
    input  logic [31-PAGE_SHIFT:0]         wr_vpn_i,
    input  logic [PPN_W-1:0]               wr_ppn_i,
    input  logic [MAT_W-1:0]               wr_mat_i,
    input  logic [PLV_W-1:0]               wr_plv_i,
    input  logic                           wr_valid_i,
    input  logic [31:0]                    lookup_vaddr_i,
    output logic                           found_o,
    output logic [PPN_W-1:0]               ppn_o,
    output logic [MAT_W-1:0]               mat_o,
    output logic [PLV_W-1:0]               plv_o
);

    logic [TLB_ENTRIES-1:0] ent_valid_q;
    logic [31-PAGE_SHIFT:0] ent_vpn_q [TLB_ENTRIES];
    logic [PPN_W-1:0]       ent_ppn_q [TLB_ENTRIES];
    logic [MAT_W-1:0]       ent_mat_q [TLB_ENTRIES];
    logic [PLV_W-1:0]       ent_plv_q [TLB_ENTRIES];

    logic                   hit;
    logic [PPN_W-1:0]       hit_ppn;
    logic [MAT_W-1:0]       hit_mat;
    logic [PLV_W-1:0]       hit_plv;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ent_valid_q <= '0;
        end else if (we_i) begin
            ent_valid_q[wr_index_i] <= wr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            ent_vpn_q[wr_index_i] <= wr_vpn_i;
            ent_ppn_q[wr_index_i] <= wr_ppn_i;
            ent_mat_q[wr_index_i] <= wr_mat_i;
            ent_plv_q[wr_index_i] <= wr_plv_i;
        end
    end

    // scan from the top so the lowest matching index wins
    always_comb begin
        hit     = 1'b0;
        hit_ppn = '0;
        hit_mat = '0;
        hit_plv = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (ent_valid_q[i] && ent_vpn_q[i] == lookup_vaddr_i[31:PAGE_SHIFT]) begin
                hit     = 1'b1;
                hit_ppn = ent_ppn_q[i];
                hit_mat = ent_mat_q[i];
                hit_plv = ent_plv_q[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        found_o <= hit;
        ppn_o   <= hit_ppn;
        mat_o   <= hit_mat;
        plv_o   <= hit_plv;
    end

endmodule

// File: source/tlb_walk_timer.sv
module tlb_walk_timer #(
    parameter int LOOKUP_CYCLES = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,
    output logic done_o
);

    localparam int CNT_W = $clog2(LOOKUP_CYCLES + 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            done_o <= 1'b0;
        end else begin
            // one-cycle pulse as the count runs out
            done_o <= (cnt_q == CNT_W'(1));
            if (start_i) begin
                cnt_q <= CNT_W'(LOOKUP_CYCLES);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // a new miss cannot arrive before the previous walk is finished
    no_restart_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n) start_i |-> cnt_q == '0
    );

endmodule

// File: source/trans_fsm.sv
module trans_fsm
    import mmu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush_i,
    input  logic         m1_miss_i,
    input  logic         walk_done_i,
    output trans_state_e state_o
);

    trans_state_e state_q;
    trans_state_e state_d;

    always_comb begin
        state_d = state_q;
        if (flush_i) begin
            // window entries are rebuilt after every flush
            state_d = LOAD_DMW0;
        end else begin
            case (state_q)
                NORMAL: begin
                    if (m1_miss_i) begin
                        state_d = REFILL;
                    end
                end
                LOAD_DMW0: state_d = LOAD_DMW1;
                LOAD_DMW1: state_d = NORMAL;
                REFILL: begin
                    if (walk_done_i) begin
                        state_d = NORMAL;
                    end
                end
                default: state_d = NORMAL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= NORMAL;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    // the timer is only ever started on the way into refill
    walk_done_in_refill: assert property (
        @(posedge clk) disable iff (!rst_n) walk_done_i |-> state_q == REFILL
    );

endmodule

// File: testbench/tb_daddr_trans.sv
module tb_daddr_trans
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES   = 8,
    parameter int LOOKUP_CYCLES = 3
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 2000;
    localparam int SEGS       = 2 ** SEG_W;

    logic                           clk;
    logic                           rst_n;
    logic                           valid_i;
    logic [31:0]                    vaddr_i;
    logic                           m1_stall_i;
    logic                           flush_i;
    logic                           crmd_da_i;
    logic [PLV_W-1:0]               crmd_plv_i;
    logic [MAT_W-1:0]               crmd_datm_i;
    logic [SEG_W-1:0]               dmw0_vseg_i;
    logic [SEG_W-1:0]               dmw0_pseg_i;
    logic [MAT_W-1:0]               dmw0_mat_i;
    logic [PLV_W-1:0]               dmw0_plv_i;
    logic [SEG_W-1:0]               dmw1_vseg_i;
    logic [SEG_W-1:0]               dmw1_pseg_i;
    logic [MAT_W-1:0]               dmw1_mat_i;
    logic [PLV_W-1:0]               dmw1_plv_i;
    logic                           tlb_we_i;
    logic [$clog2(TLB_ENTRIES)-1:0] tlb_wr_index_i;
    logic [31-PAGE_SHIFT:0]         tlb_wr_vpn_i;
    logic [PPN_W-1:0]               tlb_wr_ppn_i;
    logic [MAT_W-1:0]               tlb_wr_mat_i;
    logic [PLV_W-1:0]               tlb_wr_plv_i;
    logic                           tlb_wr_valid_i;
    logic                           ready_o;
    logic [PPN_W-1:0]               ppn_o;
    logic [MAT_W-1:0]               mat_o;
    logic [PLV_W-1:0]               plv_o;
    logic                           found_o;
    logic                           dmw_o;

    // reference copy of the TLB as written by the tests
    logic [31-PAGE_SHIFT:0] m_vpn   [TLB_ENTRIES];
    logic [PPN_W-1:0]       m_ppn   [TLB_ENTRIES];
    logic [MAT_W-1:0]       m_mat   [TLB_ENTRIES];
    logic [PLV_W-1:0]       m_plv   [TLB_ENTRIES];
    logic                   m_valid [TLB_ENTRIES];
    // which segments should already be cached
    logic                   sc_valid [SEGS];
    logic                   sc_tlb   [SEGS];
    logic [TAG_W-1:0]       sc_tag   [SEGS];

    int     errors;
    int     cycle_count;
    integer seed;

    daddr_trans_top #(.TLB_ENTRIES(TLB_ENTRIES), .LOOKUP_CYCLES(LOOKUP_CYCLES)) u_dut (
        .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .vaddr_i(vaddr_i),
        .m1_stall_i(m1_stall_i), .flush_i(flush_i), .crmd_da_i(crmd_da_i),
        .crmd_plv_i(crmd_plv_i), .crmd_datm_i(crmd_datm_i),
        .dmw0_vseg_i(dmw0_vseg_i), .dmw0_pseg_i(dmw0_pseg_i),
        .dmw0_mat_i(dmw0_mat_i), .dmw0_plv_i(dmw0_plv_i),
        .dmw1_vseg_i(dmw1_vseg_i), .dmw1_pseg_i(dmw1_pseg_i),
        .dmw1_mat_i(dmw1_mat_i), .dmw1_plv_i(dmw1_plv_i),
        .tlb_we_i(tlb_we_i), .tlb_wr_index_i(tlb_wr_index_i), .tlb_wr_vpn_i(tlb_wr_vpn_i),
        .tlb_wr_ppn_i(tlb_wr_ppn_i), .tlb_wr_mat_i(tlb_wr_mat_i),
        .tlb_wr_plv_i(tlb_wr_plv_i), .tlb_wr_valid_i(tlb_wr_valid_i),
        .ready_o(ready_o), .ppn_o(ppn_o), .mat_o(mat_o), .plv_o(plv_o),
        .found_o(found_o), .dmw_o(dmw_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles, a test never finished", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    task automatic tlb_write(input int idx, input logic [31-PAGE_SHIFT:0] vpn,
                             input logic [PPN_W-1:0] ppn, input logic [MAT_W-1:0] mat,
                             input logic [PLV_W-1:0] plv, input logic valid);
        @(posedge clk);
        tlb_we_i       <= 1'b1;
        tlb_wr_index_i <= idx[$clog2(TLB_ENTRIES)-1:0];
        tlb_wr_vpn_i   <= vpn;
        tlb_wr_ppn_i   <= ppn;
        tlb_wr_mat_i   <= mat;
        tlb_wr_plv_i   <= plv;
        tlb_wr_valid_i <= valid;
        @(posedge clk);
        tlb_we_i <= 1'b0;
        m_vpn[idx]   = vpn;
        m_ppn[idx]   = ppn;
        m_mat[idx]   = mat;
        m_plv[idx]   = plv;
        m_valid[idx] = valid;
    endtask

    // one flush pulse, then two edges for the window preload
    task automatic flush_tables();
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        repeat (2) @(posedge clk);
        for (int s = 0; s < SEGS; s++) begin
            sc_valid[s] = 1'b0;
            sc_tlb[s]   = 1'b0;
        end
        sc_valid[dmw0_vseg_i] = 1'b1;
        sc_valid[dmw1_vseg_i] = 1'b1;
    endtask

    task automatic predict(input logic [31:0] addr, output logic [PPN_W-1:0] ppn,
                           output logic [MAT_W-1:0] mat, output logic [PLV_W-1:0] plv,
                           output logic found, output logic dmw, output logic fast);
        logic [SEG_W-1:0] seg;
        seg   = addr[31:29];
        fast  = crmd_da_i || (sc_valid[seg] && (!sc_tlb[seg] || sc_tag[seg] == addr[28:12]));
        found = 1'b1;
        dmw   = 1'b1;
        ppn   = '0;
        mat   = '0;
        plv   = '0;
        if (crmd_da_i) begin
            ppn = addr[31:12];
            mat = crmd_datm_i;
            plv = crmd_plv_i;
        end else if (seg == dmw0_vseg_i) begin
            ppn = {dmw0_pseg_i, addr[28:12]};
            mat = dmw0_mat_i;
            plv = dmw0_plv_i;
        end else if (seg == dmw1_vseg_i) begin
            ppn = {dmw1_pseg_i, addr[28:12]};
            mat = dmw1_mat_i;
            plv = dmw1_plv_i;
        end else begin
            dmw   = 1'b0;
            found = 1'b0;
            // lowest matching index wins
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                if (!found && m_valid[i] && m_vpn[i] == addr[31:12]) begin
                    found = 1'b1;
                    ppn   = m_ppn[i];
                    mat   = m_mat[i];
                    plv   = m_plv[i];
                end
            end
        end
    endtask

    task automatic access_check(input string test, input logic [31:0] addr);
        logic [PPN_W-1:0] e_ppn;
        logic [MAT_W-1:0] e_mat;
        logic [PLV_W-1:0] e_plv;
        logic             e_found;
        logic             e_dmw;
        logic             e_fast;
        int               waited;
        @(posedge clk);
        predict(addr, e_ppn, e_mat, e_plv, e_found, e_dmw, e_fast);
        valid_i    <= 1'b1;
        vaddr_i    <= addr;
        m1_stall_i <= 1'b0;
        @(posedge clk);
        valid_i    <= 1'b0;
        m1_stall_i <= 1'b1;
        @(negedge clk);
        check_value(test, "ready_o in first cycle", e_fast, ready_o);
        waited = 0;
        while (ready_o !== 1'b1 && waited < LOOKUP_CYCLES + 4) begin
            @(negedge clk);
            waited++;
        end
        if (ready_o !== 1'b1) begin
            errors++;
            $display("%s: ready_o stayed low for %0d cycles after access to %h",
                     test, waited, addr);
        end else begin
            if (!e_fast) begin
                check_value(test, "cycles to ready", LOOKUP_CYCLES + 2, waited);
            end
            check_value(test, "found_o", e_found, found_o);
            check_value(test, "dmw_o", e_dmw, dmw_o);
            if (e_found) begin
                check_value(test, "ppn_o", e_ppn, ppn_o);
                check_value(test, "mat_o", e_mat, mat_o);
                check_value(test, "plv_o", e_plv, plv_o);
            end
        end
        if (!e_fast) begin
            sc_valid[addr[31:29]] = 1'b1;
            sc_tlb[addr[31:29]]   = 1'b1;
            sc_tag[addr[31:29]]   = addr[28:12];
        end
    endtask

    task automatic window_hits();
        flush_tables();
        access_check("window_hits", 32'h8123_4567);
        access_check("window_hits", 32'h9fff_f000);
        access_check("window_hits", 32'ha000_1000);
        access_check("window_hits", 32'hb765_4321);
    endtask

    task automatic tlb_refill_and_rehit();
        tlb_write(0, 20'h00012, 20'h54321, 2'd1, 2'd3, 1'b1);
        tlb_write(1, 20'h00345, 20'h0abcd, 2'd2, 2'd1, 1'b1);
        access_check("tlb_refill_and_rehit", 32'h0001_2abc);
        access_check("tlb_refill_and_rehit", 32'h0001_2004);
    endtask

    task automatic unmapped_page();
        // present in the TLB but invalid so it must not hit
        tlb_write(2, 20'h30005, 20'h11111, 2'd3, 2'd2, 1'b0);
        access_check("unmapped_page", 32'h3000_5008);
        access_check("unmapped_page", 32'h3000_5ff0);
    endtask

    task automatic direct_addr_mode();
        @(posedge clk);
        crmd_da_i <= 1'b1;
        access_check("direct_addr_mode", 32'h0034_5678);
        access_check("direct_addr_mode", 32'hc000_0000);
        access_check("direct_addr_mode", 32'h8000_1000);
        @(posedge clk);
        crmd_da_i <= 1'b0;
    endtask

    task automatic tag_change_and_flush();
        access_check("tag_change_and_flush", 32'h0034_5100);
        access_check("tag_change_and_flush", 32'h0001_2000);
        flush_tables();
        access_check("tag_change_and_flush", 32'h0034_5200);
        access_check("tag_change_and_flush", 32'h0034_5300);
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] addr;
        int          kind;
        int          idx;
        for (int i = 4; i < 8; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            tlb_write(i, {3'(i - 4), r[16:0]}, r2[19:0], r[18:17], r[20:19], 1'b1);
        end
        for (int n = 0; n < 20; n++) begin
            kind = {$random(seed)} % 3;
            r    = $random(seed);
            case (kind)
                0: addr = {(r[0] ? dmw1_vseg_i : dmw0_vseg_i), r[29:1]};
                1: begin
                    idx  = 4 + r[1:0];
                    addr = {m_vpn[idx], r[13:2]};
                end
                // segments 6 and 7 have neither window nor TLB entries
                default: addr = {2'b11, r[29:0]};
            endcase
            access_check($sformatf("random_mix #%0d", n), addr);
        end
    endtask

    initial begin
        seed           = 70;
        errors         = 0;
        rst_n          = 1'b0;
        valid_i        = 1'b0;
        vaddr_i        = '0;
        m1_stall_i     = 1'b1;
        flush_i        = 1'b0;
        crmd_da_i      = 1'b0;
        crmd_plv_i     = 2'd1;
        crmd_datm_i    = 2'd2;
        dmw0_vseg_i    = 3'd4;
        dmw0_pseg_i    = 3'd1;
        dmw0_mat_i     = 2'd1;
        dmw0_plv_i     = 2'd0;
        dmw1_vseg_i    = 3'd5;
        dmw1_pseg_i    = 3'd6;
        dmw1_mat_i     = 2'd0;
        dmw1_plv_i     = 2'd3;
        tlb_we_i       = 1'b0;
        tlb_wr_index_i = '0;
        tlb_wr_vpn_i   = '0;
        tlb_wr_ppn_i   = '0;
        tlb_wr_mat_i   = '0;
        tlb_wr_plv_i   = '0;
        tlb_wr_valid_i = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int s = 0; s < SEGS; s++) begin
            sc_valid[s] = 1'b0;
            sc_tlb[s]   = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        window_hits();
        tlb_refill_and_rehit();
        unmapped_page();
        direct_addr_mode();
        tag_change_and_flush();
        random_mix();
        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
